// ==== common/core_check_pkg.sv ====
// Shared types and constants for the core runtime checker
// Exception classes cover only bus fault, illegal, ECALL and EBREAK traps
`default_nettype none

package core_check_pkg;

  ////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////////////////////////

  // Program counter and mepc values
  typedef logic [31:0] pc_t;

  // Exception code field of mcause
  typedef logic [4:0] exc_code_t;

  // Bus memory type where bit 0 marks a bufferable access
  typedef logic [1:0] memtype_t;

  // Atomic operation code of the data bus, zero for plain accesses
  typedef logic [5:0] atop_t;

  ////////////////////////////////////////////////////////////
  // Exception classes
  ////////////////////////////////////////////////////////////

  // Each class owns one bit of the per-class flag vectors
  typedef enum logic [1:0] {
    EXC_INSTR_ERR = 2'd0,
    EXC_ILLEGAL   = 2'd1,
    EXC_ECALL     = 2'd2,
    EXC_EBREAK    = 2'd3
  } exc_class_e;

  localparam int NUM_EXC_CLASSES = 4;

  // The mcause codes that map onto the classes above
  localparam exc_code_t CAUSE_INSTR_BUS_FAULT = 5'd1;
  localparam exc_code_t CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam exc_code_t CAUSE_BREAKPOINT      = 5'd3;
  localparam exc_code_t CAUSE_ECALL_MMODE     = 5'd11;

  // Single-step watcher states
  typedef enum logic [1:0] {
    STEP_IDLE  = 2'd0,
    STEP_ARMED = 2'd1,
    STEP_IRQ   = 2'd2
  } step_state_e;

endpackage

`default_nettype wire

// ==== compile.f ====
common/core_check_pkg.sv
mepc_check/wb_exc_classifier.sv
mepc_check/mepc_tracker.sv
logic/step_monitor.sv
logic/memattr_monitor.sv
logic/core_checker_top.sv
testbench/tb_core_checker.sv

// ==== logic/core_checker_top.sv ====
// Runtime checker for the trap and debug behaviour of the core
// All inputs are sampled every cycle and all outputs stay set until reset
`default_nettype none

module core_checker_top
  import core_check_pkg::*;
#(
  parameter bit A_EXT = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_ni,
  // Writeback stage
  input  logic                       wb_instr_valid_i,
  input  logic                       wb_bus_err_i,
  input  logic                       wb_illegal_i,
  input  logic                       wb_sys_en_i,
  input  logic                       wb_ecall_i,
  input  logic                       wb_ebrk_i,
  input  pc_t                        wb_pc_i,
  input  logic                       wb_valid_i,
  // Controller
  input  logic                       irq_ack_i,
  input  logic                       debug_pending_i,
  input  logic                       debug_allowed_i,
  input  logic                       nmi_trap_i,
  input  logic                       debug_mode_next_i,
  input  logic                       debug_mode_i,
  input  logic                       step_i,
  // CSR unit
  input  logic                       csr_save_cause_i,
  input  logic                       cause_irq_i,
  input  exc_code_t                  cause_code_i,
  input  pc_t                        mepc_next_i,
  // Instruction and data bus
  input  memtype_t                   instr_memtype_i,
  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  memtype_t                   data_memtype_i,
  input  atop_t                      data_atop_i,
  output logic [NUM_EXC_CLASSES-1:0] mepc_checked_o,
  output logic [NUM_EXC_CLASSES-1:0] mepc_mismatch_o,
  output logic                       step_error_o,
  output logic [2:0]                 mem_error_o
);

  logic       exc_valid;
  exc_class_e exc_class;
  pc_t        exc_pc;

  wb_exc_classifier u_classifier (
    .clk, .rst_ni, .wb_instr_valid_i, .wb_bus_err_i, .wb_illegal_i,
    .wb_sys_en_i, .wb_ecall_i, .wb_ebrk_i, .wb_pc_i, .irq_ack_i,
    .debug_pending_i, .debug_allowed_i, .nmi_trap_i, .debug_mode_next_i,
    .exc_valid_o (exc_valid),
    .exc_class_o (exc_class),
    .exc_pc_o    (exc_pc)
  );

  mepc_tracker u_tracker (
    .clk, .rst_ni,
    .exc_valid_i (exc_valid),
    .exc_class_i (exc_class),
    .exc_pc_i    (exc_pc),
    .csr_save_cause_i, .cause_irq_i, .cause_code_i, .mepc_next_i,
    .checked_o   (mepc_checked_o),
    .mismatch_o  (mepc_mismatch_o)
  );

  step_monitor u_step (
    .clk, .rst_ni, .wb_valid_i, .step_i, .debug_mode_i, .irq_ack_i, .step_error_o
  );

  memattr_monitor #(.A_EXT(A_EXT)) u_memattr (
    .clk, .rst_ni, .instr_memtype_i, .data_req_i, .data_we_i,
    .data_memtype_i, .data_atop_i, .mem_error_o
  );

endmodule

`default_nettype wire

// ==== logic/memattr_monitor.sv ====
// Sticky checks on the bufferable bit of fetch, load and atomic accesses
// Stores are free to be bufferable and are never flagged
`default_nettype none

module memattr_monitor
  import core_check_pkg::*;
#(
  parameter bit A_EXT = 1'b0
) (
  input  logic       clk,
  input  logic       rst_ni,
  input  memtype_t   instr_memtype_i,
  input  logic       data_req_i,
  input  logic       data_we_i,
  input  memtype_t   data_memtype_i,
  input  atop_t      data_atop_i,
  output logic [2:0] mem_error_o
);

  localparam int ERR_FETCH  = 0;
  localparam int ERR_LOAD   = 1;
  localparam int ERR_ATOMIC = 2;

  logic [2:0] err_d;
  logic [2:0] mem_error_q;

  // The fetch memory type is checked every cycle, whatever the request state
  assign err_d[ERR_FETCH] = instr_memtype_i[0];
  assign err_d[ERR_LOAD]  = data_req_i && !data_we_i && data_memtype_i[0];

  // Without atomics any nonzero code is illegal
  if (!A_EXT) begin : g_no_atomics
    assign err_d[ERR_ATOMIC] = |data_atop_i;
  end else begin : g_atomics
    assign err_d[ERR_ATOMIC] = data_req_i && (|data_atop_i) && data_memtype_i[0];
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      mem_error_q <= '0;
    end else begin
      mem_error_q <= mem_error_q | err_d;
    end
  end

  assign mem_error_o = mem_error_q;

endmodule

`default_nettype wire

// ==== logic/step_monitor.sv ====
// Flags extra retirements while single stepping outside debug mode
// The core is expected to enter debug mode after the single stepped instruction
`default_nettype none

module step_monitor
  import core_check_pkg::*;
(
  input  logic clk,
  input  logic rst_ni,
  input  logic wb_valid_i,
  input  logic step_i,
  input  logic debug_mode_i,
  input  logic irq_ack_i,
  output logic step_error_o
);

  step_state_e state_q;
  step_state_e state_d;
  logic        stepping;
  logic        err_d;
  logic        step_error_q;

  // Stepping only counts while the core runs outside debug mode
  assign stepping = step_i && !debug_mode_i;

  always_comb begin
    state_d = state_q;
    err_d   = 1'b0;
    case (state_q)
      STEP_IDLE: begin
        if (stepping && irq_ack_i) begin
          // Nothing may retire alongside the interrupt acknowledge
          err_d   = wb_valid_i;
          state_d = STEP_IRQ;
        end else if (stepping && wb_valid_i) begin
          state_d = STEP_ARMED;
        end
      end
      STEP_ARMED: begin
        if (debug_mode_i) begin
          state_d = STEP_IDLE;
        end else if (step_i && irq_ack_i) begin
          err_d   = wb_valid_i;
          state_d = STEP_IRQ;
        end else begin
          // The stepped instruction already retired
          err_d = wb_valid_i;
        end
      end
      STEP_IRQ: begin
        // The cycle after the acknowledge must stay quiet as well
        err_d   = wb_valid_i;
        state_d = STEP_IDLE;
      end
      default: state_d = STEP_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= STEP_IDLE;
      step_error_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      step_error_q <= step_error_q | err_d;
    end
  end

  assign step_error_o = step_error_q;

  a_state_legal : assert property (@(posedge clk) disable iff (!rst_ni)
    state_q inside {STEP_IDLE, STEP_ARMED, STEP_IRQ});

endmodule

`default_nettype wire

// ==== mepc_check/mepc_tracker.sv ====
// Compares the first expected and the first saved mepc of each exception class
// Interrupt causes and unknown exception codes are ignored on the CSR side
`default_nettype none

module mepc_tracker
  import core_check_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       exc_valid_i,
  input  exc_class_e                 exc_class_i,
  input  pc_t                        exc_pc_i,
  input  logic                       csr_save_cause_i,
  input  logic                       cause_irq_i,
  input  exc_code_t                  cause_code_i,
  input  pc_t                        mepc_next_i,
  output logic [NUM_EXC_CLASSES-1:0] checked_o,
  output logic [NUM_EXC_CLASSES-1:0] mismatch_o
);

  logic [NUM_EXC_CLASSES-1:0] exp_found_q;
  logic [NUM_EXC_CLASSES-1:0] act_found_q;
  logic [NUM_EXC_CLASSES-1:0] checked_q;
  logic [NUM_EXC_CLASSES-1:0] mismatch_q;
  pc_t                        exp_pc_q [NUM_EXC_CLASSES];
  pc_t                        act_pc_q [NUM_EXC_CLASSES];
  logic                       cause_hit;
  exc_class_e                 cause_class;
  logic                       exp_capture;
  logic                       act_capture;

  ////////////////////////////////////////////////////////////
  // Capture of the first value on each side
  ////////////////////////////////////////////////////////////

  // Map the saved exception code back onto a class
  always_comb begin
    cause_hit   = 1'b1;
    cause_class = EXC_INSTR_ERR;
    case (cause_code_i)
      CAUSE_INSTR_BUS_FAULT: cause_class = EXC_INSTR_ERR;
      CAUSE_ILLEGAL_INSN:    cause_class = EXC_ILLEGAL;
      CAUSE_ECALL_MMODE:     cause_class = EXC_ECALL;
      CAUSE_BREAKPOINT:      cause_class = EXC_EBREAK;
      default:               cause_hit   = 1'b0;
    endcase
  end

  assign exp_capture = exc_valid_i && !exp_found_q[exc_class_i];
  assign act_capture = csr_save_cause_i && !cause_irq_i && cause_hit &&
                       !act_found_q[cause_class];

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q <= '0;
      act_found_q <= '0;
    end else begin
      if (exp_capture) exp_found_q[exc_class_i] <= 1'b1;
      if (act_capture) act_found_q[cause_class] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (exp_capture) exp_pc_q[exc_class_i] <= exc_pc_i;
    if (act_capture) act_pc_q[cause_class] <= mepc_next_i;
  end

  ////////////////////////////////////////////////////////////
  // Compare and sticky flags
  ////////////////////////////////////////////////////////////

  // Checked rises once both captures exist and the compare follows a cycle later
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q  <= '0;
      mismatch_q <= '0;
    end else begin
      for (int i = 0; i < NUM_EXC_CLASSES; i++) begin
        checked_q[i]  <= checked_q[i] | (exp_found_q[i] & act_found_q[i]);
        mismatch_q[i] <= mismatch_q[i] | (checked_q[i] & (exp_pc_q[i] != act_pc_q[i]));
      end
    end
  end

  assign checked_o  = checked_q;
  assign mismatch_o = mismatch_q;

  // Only the first occurrence counts, so a captured value is frozen until reset
  for (genvar g = 0; g < NUM_EXC_CLASSES; g++) begin : g_frozen
    a_exp_frozen : assert property (@(posedge clk) disable iff (!rst_ni)
      exp_found_q[g] |=> $stable(exp_pc_q[g]));
    a_act_frozen : assert property (@(posedge clk) disable iff (!rst_ni)
      act_found_q[g] |=> $stable(act_pc_q[g]));
  end

endmodule

`default_nettype wire

// ==== mepc_check/wb_exc_classifier.sv ====
// Emits one registered strobe per qualifying trapping instruction in writeback
// Only one class is reported per instruction, picked by trap priority
`default_nettype none

module wb_exc_classifier
  import core_check_pkg::*;
(
  input  logic       clk,
  input  logic       rst_ni,
  input  logic       wb_instr_valid_i,
  input  logic       wb_bus_err_i,
  input  logic       wb_illegal_i,
  input  logic       wb_sys_en_i,
  input  logic       wb_ecall_i,
  input  logic       wb_ebrk_i,
  input  pc_t        wb_pc_i,
  input  logic       irq_ack_i,
  input  logic       debug_pending_i,
  input  logic       debug_allowed_i,
  input  logic       nmi_trap_i,
  input  logic       debug_mode_next_i,
  output logic       exc_valid_o,
  output exc_class_e exc_class_o,
  output pc_t        exc_pc_o
);

  logic       qualified;
  logic       exc_hit;
  exc_class_e exc_class_d;
  logic       exc_valid_q;
  exc_class_e exc_class_q;
  pc_t        exc_pc_q;

  // An interrupt, a debug entry or an NMI takes the trap instead of the instruction
  assign qualified = wb_instr_valid_i && !irq_ack_i &&
                     !(debug_pending_i && debug_allowed_i) &&
                     !nmi_trap_i && !debug_mode_next_i;

  // Bus error wins over illegal, illegal over ECALL, ECALL over EBREAK
  always_comb begin
    exc_hit     = qualified;
    exc_class_d = EXC_INSTR_ERR;
    if (wb_bus_err_i) begin
      exc_class_d = EXC_INSTR_ERR;
    end else if (wb_illegal_i) begin
      exc_class_d = EXC_ILLEGAL;
    end else if (wb_sys_en_i && wb_ecall_i) begin
      exc_class_d = EXC_ECALL;
    end else if (wb_sys_en_i && wb_ebrk_i) begin
      exc_class_d = EXC_EBREAK;
    end else begin
      exc_hit = 1'b0;
    end
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exc_valid_q <= 1'b0;
    end else begin
      exc_valid_q <= exc_hit;
    end
  end

  // Class and PC are only meaningful while the strobe is high
  always_ff @(posedge clk) begin
    if (exc_hit) begin
      exc_class_q <= exc_class_d;
      exc_pc_q    <= wb_pc_i;
    end
  end

  assign exc_valid_o = exc_valid_q;
  assign exc_class_o = exc_class_q;
  assign exc_pc_o    = exc_pc_q;

  // A trapping instruction leaves writeback once, so its PC is never reported twice
  a_no_double_report : assert property (@(posedge clk) disable iff (!rst_ni)
    exc_valid_o |=> !(exc_valid_o && (exc_pc_o == $past(exc_pc_o))));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f compile.f --top-module tb_core_checker \
  -o sim_core_checker > build.log 2>&1 \
  && ./obj_dir/sim_core_checker > sim.log 2>&1 \
  || echo "Build or simulation did not complete, see build.log" >> sim.log

cat sim.log
grep -q '>>> FAIL' sim.log && exit 1
grep -q '>>> PASS' sim.log || exit 1
exit 0

// ==== testbench/tb_core_checker.sv ====
// Directed testbench for core_checker_top with atomics disabled
// Each writeback and each CSR save is held for exactly one clock
`default_nettype none

module tb_core_checker;
  timeunit 1ns;
  timeprecision 1ps;

  // Class indices follow the per-class flag vectors of the checker
  localparam logic [1:0] CLS_INSTR_ERR = 2'd0;
  localparam logic [1:0] CLS_ILLEGAL   = 2'd1;
  localparam logic [1:0] CLS_ECALL     = 2'd2;
  localparam logic [1:0] CLS_EBREAK    = 2'd3;
  localparam int         WAIT_LIMIT    = 20;

  logic        clk = 1'b0;
  logic        rst_ni;
  logic        wb_instr_valid_i, wb_bus_err_i, wb_illegal_i, wb_sys_en_i;
  logic        wb_ecall_i, wb_ebrk_i, wb_valid_i;
  logic [31:0] wb_pc_i;
  logic        irq_ack_i, debug_pending_i, debug_allowed_i, nmi_trap_i;
  logic        debug_mode_next_i, debug_mode_i, step_i;
  logic        csr_save_cause_i, cause_irq_i;
  logic [4:0]  cause_code_i;
  logic [31:0] mepc_next_i;
  logic [1:0]  instr_memtype_i, data_memtype_i;
  logic        data_req_i, data_we_i;
  logic [5:0]  data_atop_i;
  logic [3:0]  mepc_checked_o, mepc_mismatch_o;
  logic        step_error_o;
  logic [2:0]  mem_error_o;
  integer      seed = 32'h9885;
  int          errors = 0;
  int          checks = 0;

  always #10 clk = ~clk;

  core_checker_top #(.A_EXT(1'b0)) DUT (.*);

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic drive_idle();
    wb_instr_valid_i  <= 1'b0;
    wb_bus_err_i      <= 1'b0;
    wb_illegal_i      <= 1'b0;
    wb_sys_en_i       <= 1'b0;
    wb_ecall_i        <= 1'b0;
    wb_ebrk_i         <= 1'b0;
    wb_valid_i        <= 1'b0;
    wb_pc_i           <= '0;
    irq_ack_i         <= 1'b0;
    debug_pending_i   <= 1'b0;
    debug_allowed_i   <= 1'b0;
    nmi_trap_i        <= 1'b0;
    debug_mode_next_i <= 1'b0;
    debug_mode_i      <= 1'b0;
    step_i            <= 1'b0;
    csr_save_cause_i  <= 1'b0;
    cause_irq_i       <= 1'b0;
    cause_code_i      <= '0;
    mepc_next_i       <= '0;
    instr_memtype_i   <= '0;
    data_memtype_i    <= '0;
    data_req_i        <= 1'b0;
    data_we_i         <= 1'b0;
    data_atop_i       <= '0;
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_ni <= 1'b0;
    drive_idle();
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;
  endtask

  // mcause exception codes of the four trap classes
  function automatic logic [4:0] cause_for_class(input logic [1:0] cls);
    case (cls)
      CLS_INSTR_ERR: return 5'd1;
      CLS_ILLEGAL:   return 5'd2;
      CLS_ECALL:     return 5'd11;
      default:       return 5'd3;
    endcase
  endfunction

  // One writeback cycle, system instructions always enabled
  task automatic drive_wb(input logic [31:0] pc, input logic bus_err, illegal, ecall, ebrk,
                          input logic irq_ack);
    @(posedge clk);
    wb_instr_valid_i <= 1'b1;
    wb_bus_err_i     <= bus_err;
    wb_illegal_i     <= illegal;
    wb_sys_en_i      <= 1'b1;
    wb_ecall_i       <= ecall;
    wb_ebrk_i        <= ebrk;
    wb_pc_i          <= pc;
    irq_ack_i        <= irq_ack;
    @(posedge clk);
    drive_idle();
  endtask

  task automatic save_cause(input logic [4:0] code, input logic [31:0] mepc);
    @(posedge clk);
    csr_save_cause_i <= 1'b1;
    cause_irq_i      <= 1'b0;
    cause_code_i     <= code;
    mepc_next_i      <= mepc;
    @(posedge clk);
    drive_idle();
  endtask

  task automatic wait_checked(input string test, input logic [1:0] cls);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!mepc_checked_o[cls] && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!mepc_checked_o[cls]) begin
      $display("%s: checked bit of class %0d never rose", test, cls);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_matching_mepc();
    logic [31:0] pc;
    logic [1:0]  cls;
    reset_dut();
    for (int i = 0; i < 4; i++) begin
      cls = i[1:0];
      pc = $random(seed);
      pc[1:0] = 2'b00;
      drive_wb(pc, cls == CLS_INSTR_ERR, cls == CLS_ILLEGAL, cls == CLS_ECALL,
               cls == CLS_EBREAK, 1'b0);
      save_cause(cause_for_class(cls), pc);
      wait_checked("matching_mepc", cls);
      // Give the compare its extra cycle
      @(negedge clk);
      checks++;
      if (mepc_mismatch_o[cls] !== 1'b0) begin
        $display("FAIL matching_mepc class %0d: expected %0b, actual %0b",
                 cls, 1'b0, mepc_mismatch_o[cls]);
        errors++;
      end
    end
  endtask

  task automatic test_mepc_mismatch();
    logic [31:0] pc;
    reset_dut();
    pc = $random(seed);
    pc[1:0] = 2'b00;
    drive_wb(pc, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    save_cause(5'd11, pc + 32'd4);
    wait_checked("mepc_mismatch", CLS_ECALL);
    @(negedge clk);
    checks++;
    if (mepc_mismatch_o[CLS_ECALL] !== 1'b1) begin
      $display("FAIL mepc_mismatch: expected %0b, actual %0b", 1'b1,
               mepc_mismatch_o[CLS_ECALL]);
      errors++;
    end
  endtask

  task automatic test_priority();
    logic [31:0] pc;
    reset_dut();
    pc = $random(seed);
    pc[1:0] = 2'b00;
    // Bus error outranks illegal, so only the instr-err class sees this PC
    drive_wb(pc, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    save_cause(5'd1, pc);
    wait_checked("priority", CLS_INSTR_ERR);
    save_cause(5'd2, pc);
    repeat (4) @(negedge clk);
    checks++;
    if (mepc_checked_o[CLS_ILLEGAL] !== 1'b0 || mepc_mismatch_o !== 4'b0000) begin
      $display("FAIL priority: expected checked %b, actual %b, mismatch %b",
               4'b0001, mepc_checked_o, mepc_mismatch_o);
      errors++;
    end
  endtask

  task automatic test_qualifier_gating();
    logic [31:0] pc_q;
    reset_dut();
    pc_q = $random(seed);
    pc_q[1:0] = 2'b00;
    // The interrupt takes the first instruction, so its PC is never expected
    drive_wb(pc_q ^ 32'h0000_0100, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    drive_wb(pc_q, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    save_cause(5'd2, pc_q);
    wait_checked("qualifier_gating", CLS_ILLEGAL);
    @(negedge clk);
    checks++;
    if (mepc_mismatch_o[CLS_ILLEGAL] !== 1'b0) begin
      $display("FAIL qualifier_gating: expected %0b, actual %0b", 1'b0,
               mepc_mismatch_o[CLS_ILLEGAL]);
      errors++;
    end
  endtask

  task automatic test_single_step();
    reset_dut();
    @(posedge clk);
    step_i     <= 1'b1;
    wb_valid_i <= 1'b1;
    // Retirement stays high for a second cycle
    @(posedge clk);
    @(posedge clk);
    wb_valid_i <= 1'b0;
    @(negedge clk);
    checks++;
    if (step_error_o !== 1'b1) begin
      $display("FAIL single_step double retire: expected %0b, actual %0b", 1'b1, step_error_o);
      errors++;
    end
    reset_dut();
    @(posedge clk);
    step_i     <= 1'b1;
    wb_valid_i <= 1'b1;
    @(posedge clk);
    wb_valid_i   <= 1'b0;
    debug_mode_i <= 1'b1;
    // Code running in debug mode retires without counting as a step
    @(posedge clk);
    wb_valid_i <= 1'b1;
    @(posedge clk);
    wb_valid_i <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checks++;
    if (step_error_o !== 1'b0) begin
      $display("FAIL single_step into debug: expected %0b, actual %0b", 1'b0, step_error_o);
      errors++;
    end
  endtask

  // One bus cycle after a fresh reset, then the sticky error vector is compared
  task automatic run_mem_access(input string label, input logic [1:0] imem, input logic req, we,
                                input logic [1:0] dmem, input logic [5:0] atop,
                                input logic [2:0] expected);
    reset_dut();
    @(posedge clk);
    instr_memtype_i <= imem;
    data_req_i      <= req;
    data_we_i       <= we;
    data_memtype_i  <= dmem;
    data_atop_i     <= atop;
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    checks++;
    if (mem_error_o !== expected) begin
      $display("FAIL %s: expected %b, actual %b", label, expected, mem_error_o);
      errors++;
    end
  endtask

  task automatic test_mem_attributes();
    logic [31:0] rnd;
    rnd = $random(seed);
    run_mem_access("mem_fetch", 2'b01, 1'b0, 1'b0, 2'b00, 6'h00, 3'b001);
    run_mem_access("mem_load", 2'b00, 1'b1, 1'b0, 2'b01, 6'h00, 3'b010);
    run_mem_access("mem_atomic", 2'b00, 1'b1, 1'b1, 2'b00, {rnd[5:1], 1'b1}, 3'b100);
    run_mem_access("mem_store", 2'b00, 1'b1, 1'b1, 2'b00, 6'h00, 3'b000);
  endtask

  initial begin
    rst_ni <= 1'b0;
    drive_idle();
    test_matching_mepc();
    test_mepc_mismatch();
    test_priority();
    test_qualifier_gating();
    test_single_step();
    test_mem_attributes();
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
